// ==== design/audio_pkg.sv ====
package audio_pkg;

	////////////////////////////////////////
	// sample and fixed-point formats
	////////////////////////////////////////

	// signed 16-bit audio sample
	typedef logic signed [15:0] sample_t;
	// signed 2.16, coefficients and filter state
	typedef logic signed [17:0] coeff_t;

	// bus word formats
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0]  byte_en_t;
	typedef logic [7:0]  fifo_level_t;

	////////////////////////////////////////
	// audio core registers
	////////////////////////////////////////

	localparam bus_addr_t audio_fifo_addr  = 32'h0000_3044;
	localparam bus_addr_t audio_left_addr  = 32'h0000_3048;
	localparam bus_addr_t audio_right_addr = 32'h0000_304C;
	localparam byte_en_t  byte_en_all      = 4'b1111;

	// write only when space is above this
	localparam fifo_level_t write_space_min = 8'd2;

	// 48 kHz down to 8 kHz
	localparam int decim_ratio = 6;
	typedef logic [$clog2(decim_ratio)-1:0] decim_cnt_t;
	localparam decim_cnt_t decim_last = decim_cnt_t'(decim_ratio - 1);

	////////////////////////////////////////
	// filter coefficients, a terms pre-negated
	////////////////////////////////////////

	// 300 Hz bandpass at 48 kHz
	localparam coeff_t bp300_b1 = 18'sd426;
	localparam coeff_t bp300_b2 = 18'sd0;
	localparam coeff_t bp300_b3 = -18'sd426;
	localparam coeff_t bp300_a2 = 18'sd130122;
	localparam coeff_t bp300_a3 = -18'sd64683;

	// first decimation low-pass, about 4 kHz
	localparam coeff_t dec1_b1 = 18'sd885;
	localparam coeff_t dec1_b2 = 18'sd1771;
	localparam coeff_t dec1_b3 = 18'sd885;
	localparam coeff_t dec1_a2 = 18'sd112357;
	localparam coeff_t dec1_a3 = -18'sd56805;

	// second decimation low-pass, about 2 kHz
	localparam coeff_t dec2_b1 = 18'sd943;
	localparam coeff_t dec2_b2 = 18'sd1887;
	localparam coeff_t dec2_b3 = 18'sd943;
	localparam coeff_t dec2_a2 = 18'sd107019;
	localparam coeff_t dec2_a3 = -18'sd45259;

	// 300 Hz bandpass at 8 kHz
	localparam coeff_t bp300d_b1 = 18'sd2477;
	localparam coeff_t bp300d_b2 = 18'sd0;
	localparam coeff_t bp300d_b3 = -18'sd2477;
	localparam coeff_t bp300d_a2 = 18'sd122726;
	localparam coeff_t bp300d_a3 = -18'sd60580;

	////////////////////////////////////////
	// bus master FSM
	////////////////////////////////////////

	typedef enum logic [3:0] {
		bm_poll_wr,
		bm_await_wr,
		bm_decide_wr,
		bm_write_left,
		bm_write_right_setup,
		bm_write_right,
		bm_poll_rd,
		bm_await_rd,
		bm_decide_rd,
		bm_read_left,
		bm_read_right_setup,
		bm_read_right,
		bm_strobe
	} bm_state_t;

endpackage

// ==== design/iir2_biquad.sv ====
module iir2_biquad #(
	parameter audio_pkg::coeff_t b1 = 18'sd0,
	parameter audio_pkg::coeff_t b2 = 18'sd0,
	parameter audio_pkg::coeff_t b3 = 18'sd0,
	parameter audio_pkg::coeff_t a2 = 18'sd0,
	parameter audio_pkg::coeff_t a3 = 18'sd0
) (
	input  logic               CLOCK_50,
	input  logic               reset,
	input  logic               strobe,
	input  audio_pkg::sample_t sample_in,
	output audio_pkg::sample_t sample_out
);

	// idle, then one state per MAC term, then history update
	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_b2,
		st_b3,
		st_a2,
		st_a3,
		st_update
	} bq_state_t;

	bq_state_t state;

	// shared MAC operands and running sum
	audio_pkg::coeff_t mac_coeff;
	audio_pkg::coeff_t mac_value;
	audio_pkg::coeff_t acc;
	audio_pkg::coeff_t acc_next;
	audio_pkg::coeff_t term;
	logic signed [35:0] product;

	// input and output history
	audio_pkg::coeff_t x_ext;
	audio_pkg::coeff_t x_n;
	audio_pkg::coeff_t x_n1;
	audio_pkg::coeff_t x_n2;
	audio_pkg::coeff_t y_n1;
	audio_pkg::coeff_t y_n2;

	////////////////////////////////////////
	// 18x18 multiply, back to 2.16
	////////////////////////////////////////

	assign product  = mac_coeff * mac_value;
	// keep sign, drop the two redundant integer bits
	assign term     = {product[35], product[32:16]};
	assign acc_next = acc + term;

	// sample widened into the 2.16 word
	assign x_ext = {{2{sample_in[15]}}, sample_in};

	////////////////////////////////////////
	// term sequencer
	////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state      <= st_idle;
			sample_out <= '0;
			acc        <= '0;
			mac_coeff  <= '0;
			mac_value  <= '0;
			x_n        <= '0;
			x_n1       <= '0;
			x_n2       <= '0;
			y_n1       <= '0;
			y_n2       <= '0;
		end else begin
			case (state)
				st_idle: begin
					// acc_next still holds the last y(n)
					if (strobe) begin
						sample_out <= acc_next[15:0];
						state      <= st_load;
					end
				end
				st_load: begin
					// b1 * x(n)
					acc       <= '0;
					mac_coeff <= b1;
					mac_value <= x_ext;
					x_n       <= x_ext;
					state     <= st_b2;
				end
				st_b2: begin
					acc       <= acc_next;
					mac_coeff <= b2;
					mac_value <= x_n1;
					state     <= st_b3;
				end
				st_b3: begin
					acc       <= acc_next;
					mac_coeff <= b3;
					mac_value <= x_n2;
					state     <= st_a2;
				end
				st_a2: begin
					// feedback terms, signs already in a2/a3
					acc       <= acc_next;
					mac_coeff <= a2;
					mac_value <= y_n1;
					state     <= st_a3;
				end
				st_a3: begin
					acc       <= acc_next;
					mac_coeff <= a3;
					mac_value <= y_n2;
					state     <= st_update;
				end
				st_update: begin
					// all five terms summed here
					y_n1  <= acc_next;
					y_n2  <= y_n1;
					x_n1  <= x_n;
					x_n2  <= x_n1;
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// one sample computation is bounded
	assert property (@(posedge CLOCK_50) disable iff (reset)
		(state == st_idle) ##1 (state != st_idle) |-> ##[1:7] (state == st_idle));

endmodule

// ==== design/audio_filter_bank.sv ====
module audio_filter_bank (
	input  logic               CLOCK_50,
	input  logic               reset,
	input  logic               sample_valid,
	input  logic               decim_valid,
	input  logic               filter_right_en,
	input  logic               filter_left_en,
	input  audio_pkg::sample_t left_in,
	input  audio_pkg::sample_t right_in,
	output audio_pkg::sample_t left_out,
	output audio_pkg::sample_t right_out
);

	audio_pkg::sample_t bp_right;
	audio_pkg::sample_t decim1_out;
	audio_pkg::sample_t decim2_out;
	audio_pkg::sample_t decim_scaled;
	audio_pkg::sample_t bp_decim;

	////////////////////////////////////////
	// right channel, 48 kHz bandpass
	////////////////////////////////////////

	iir2_biquad #(
		.b1(audio_pkg::bp300_b1),
		.b2(audio_pkg::bp300_b2),
		.b3(audio_pkg::bp300_b3),
		.a2(audio_pkg::bp300_a2),
		.a3(audio_pkg::bp300_a3)
	) u_bp300_right (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.strobe    (sample_valid),
		.sample_in (right_in),
		.sample_out(bp_right)
	);

	////////////////////////////////////////
	// left channel, 6:1 decimation chain
	////////////////////////////////////////

	// both low-pass stages run at full rate
	iir2_biquad #(
		.b1(audio_pkg::dec1_b1),
		.b2(audio_pkg::dec1_b2),
		.b3(audio_pkg::dec1_b3),
		.a2(audio_pkg::dec1_a2),
		.a3(audio_pkg::dec1_a3)
	) u_decim1 (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.strobe    (sample_valid),
		.sample_in (left_in),
		.sample_out(decim1_out)
	);

	iir2_biquad #(
		.b1(audio_pkg::dec2_b1),
		.b2(audio_pkg::dec2_b2),
		.b3(audio_pkg::dec2_b3),
		.a2(audio_pkg::dec2_a2),
		.a3(audio_pkg::dec2_a3)
	) u_decim2 (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.strobe    (sample_valid),
		.sample_in (decim1_out),
		.sample_out(decim2_out)
	);

	// make up the gain lost in the decimator
	assign decim_scaled = {decim2_out[14:0], 1'b0};

	// bandpass only sees every sixth sample
	iir2_biquad #(
		.b1(audio_pkg::bp300d_b1),
		.b2(audio_pkg::bp300d_b2),
		.b3(audio_pkg::bp300d_b3),
		.a2(audio_pkg::bp300d_a2),
		.a3(audio_pkg::bp300d_a3)
	) u_bp300_decim (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.strobe    (decim_valid),
		.sample_in (decim_scaled),
		.sample_out(bp_decim)
	);

	// filtered or looped back, per channel
	assign right_out = filter_right_en ? bp_right : right_in;
	assign left_out  = filter_left_en ? bp_decim : left_in;

endmodule

// ==== design/audio_bus_master.sv ====
module audio_bus_master (
	input  logic                    CLOCK_50,
	input  logic                    reset,
	input  logic                    bus_ack,
	input  audio_pkg::bus_data_t    bus_read_data,
	input  audio_pkg::sample_t      left_out,
	input  audio_pkg::sample_t      right_out,
	output audio_pkg::bus_addr_t    bus_addr,
	output audio_pkg::byte_en_t     bus_byte_enable,
	output logic                    bus_read,
	output logic                    bus_write,
	output logic                    sample_valid,
	output logic                    decim_valid,
	output audio_pkg::bus_data_t    bus_write_data,
	output audio_pkg::sample_t      left_in,
	output audio_pkg::sample_t      right_in,
	output audio_pkg::fifo_level_t  fifo_space
);

	audio_pkg::bm_state_t  state;
	audio_pkg::decim_cnt_t decim_cnt;

	////////////////////////////////////////
	// poll, write pair, read pair, strobe
	////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state           <= audio_pkg::bm_poll_wr;
			bus_addr        <= '0;
			bus_byte_enable <= '0;
			bus_read        <= 1'b0;
			bus_write       <= 1'b0;
			sample_valid    <= 1'b0;
			decim_valid     <= 1'b0;
			decim_cnt       <= '0;
			fifo_space      <= '0;
			left_in         <= '0;
			right_in        <= '0;
		end else begin
			case (state)
				// ask for the FIFO status word
				audio_pkg::bm_poll_wr: begin
					bus_addr        <= audio_pkg::audio_fifo_addr;
					bus_byte_enable <= audio_pkg::byte_en_all;
					bus_read        <= 1'b1;
					state           <= audio_pkg::bm_await_wr;
				end
				audio_pkg::bm_await_wr: begin
					// write space lives in the top byte
					if (bus_ack) begin
						fifo_space <= bus_read_data[31:24];
						bus_read   <= 1'b0;
						state      <= audio_pkg::bm_decide_wr;
					end
				end
				audio_pkg::bm_decide_wr: begin
					// too little room, go round again
					if (fifo_space > audio_pkg::write_space_min) begin
						bus_addr  <= audio_pkg::audio_left_addr;
						bus_write <= 1'b1;
						state     <= audio_pkg::bm_write_left;
					end else begin
						state <= audio_pkg::bm_poll_wr;
					end
				end
				audio_pkg::bm_write_left: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state     <= audio_pkg::bm_write_right_setup;
					end
				end
				audio_pkg::bm_write_right_setup: begin
					bus_addr  <= audio_pkg::audio_right_addr;
					bus_write <= 1'b1;
					state     <= audio_pkg::bm_write_right;
				end
				audio_pkg::bm_write_right: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state     <= audio_pkg::bm_poll_rd;
					end
				end
				// status again, now for the read side
				audio_pkg::bm_poll_rd: begin
					bus_addr <= audio_pkg::audio_fifo_addr;
					bus_read <= 1'b1;
					state    <= audio_pkg::bm_await_rd;
				end
				audio_pkg::bm_await_rd: begin
					// read level in the low byte, zero when empty
					if (bus_ack) begin
						fifo_space <= bus_read_data[7:0];
						bus_read   <= 1'b0;
						state      <= audio_pkg::bm_decide_rd;
					end
				end
				audio_pkg::bm_decide_rd: begin
					// nothing to read, no strobe this pass
					if (fifo_space != '0) begin
						bus_addr <= audio_pkg::audio_left_addr;
						bus_read <= 1'b1;
						state    <= audio_pkg::bm_read_left;
					end else begin
						state <= audio_pkg::bm_poll_wr;
					end
				end
				audio_pkg::bm_read_left: begin
					if (bus_ack) begin
						left_in  <= audio_pkg::sample_t'(bus_read_data[15:0]);
						bus_read <= 1'b0;
						state    <= audio_pkg::bm_read_right_setup;
					end
				end
				audio_pkg::bm_read_right_setup: begin
					bus_addr <= audio_pkg::audio_right_addr;
					bus_read <= 1'b1;
					state    <= audio_pkg::bm_read_right;
				end
				audio_pkg::bm_read_right: begin
					// both samples in, raise the strobes
					if (bus_ack) begin
						right_in     <= audio_pkg::sample_t'(bus_read_data[15:0]);
						bus_read     <= 1'b0;
						sample_valid <= 1'b1;
						if (decim_cnt == audio_pkg::decim_last) begin
							decim_cnt   <= '0;
							decim_valid <= 1'b1;
						end else begin
							decim_cnt <= decim_cnt + 1'b1;
						end
						state <= audio_pkg::bm_strobe;
					end
				end
				audio_pkg::bm_strobe: begin
					sample_valid <= 1'b0;
					decim_valid  <= 1'b0;
					state        <= audio_pkg::bm_poll_wr;
				end
				default: begin
					state <= audio_pkg::bm_poll_wr;
				end
			endcase
		end
	end

	// outgoing sample, loaded with each write address
	always_ff @(posedge CLOCK_50) begin
		if (state == audio_pkg::bm_decide_wr) begin
			bus_write_data <= {{16{left_out[15]}}, left_out};
		end else if (state == audio_pkg::bm_write_right_setup) begin
			bus_write_data <= {{16{right_out[15]}}, right_out};
		end
	end

	////////////////////////////////////////
	// bus protocol
	////////////////////////////////////////

	assert property (@(posedge CLOCK_50) disable iff (reset)
		!(bus_read && bus_write));

	// request stays up with a fixed address until ack
	assert property (@(posedge CLOCK_50) disable iff (reset)
		(bus_read || bus_write) && !bus_ack |=>
			(bus_read || bus_write) && $stable(bus_addr));

endmodule

// ==== design/audio_filter_top.sv ====
module audio_filter_top (
	input  logic                    CLOCK_50,
	input  logic                    reset,
	input  logic                    filter_right_en,
	input  logic                    filter_left_en,
	input  logic                    bus_ack,
	input  audio_pkg::bus_data_t    bus_read_data,
	output audio_pkg::bus_addr_t    bus_addr,
	output audio_pkg::byte_en_t     bus_byte_enable,
	output logic                    bus_read,
	output logic                    bus_write,
	output audio_pkg::bus_data_t    bus_write_data,
	output audio_pkg::fifo_level_t  fifo_space
);

	// sample path between master and filters
	audio_pkg::sample_t left_in;
	audio_pkg::sample_t right_in;
	audio_pkg::sample_t left_out;
	audio_pkg::sample_t right_out;
	logic               sample_valid;
	logic               decim_valid;

	audio_bus_master u_audio_bus_master (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.bus_ack        (bus_ack),
		.bus_read_data  (bus_read_data),
		.left_out       (left_out),
		.right_out      (right_out),
		.bus_addr       (bus_addr),
		.bus_byte_enable(bus_byte_enable),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.sample_valid   (sample_valid),
		.decim_valid    (decim_valid),
		.bus_write_data (bus_write_data),
		.left_in        (left_in),
		.right_in       (right_in),
		.fifo_space     (fifo_space)
	);

	audio_filter_bank u_audio_filter_bank (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.sample_valid   (sample_valid),
		.decim_valid    (decim_valid),
		.filter_right_en(filter_right_en),
		.filter_left_en (filter_left_en),
		.left_in        (left_in),
		.right_in       (right_in),
		.left_out       (left_out),
		.right_out      (right_out)
	);

endmodule

// ==== verif/tb_audio_filter.sv ====
module tb_audio_filter;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_passes  = 20;
	localparam int stim_cols   = 8;
	localparam int req_timeout = 50;

	logic                   CLOCK_50;
	logic                   reset;
	logic                   filter_right_en;
	logic                   filter_left_en;
	logic                   bus_ack;
	audio_pkg::bus_data_t   bus_read_data;
	audio_pkg::bus_addr_t   bus_addr;
	audio_pkg::byte_en_t    bus_byte_enable;
	logic                   bus_read;
	logic                   bus_write;
	audio_pkg::bus_data_t   bus_write_data;
	audio_pkg::fifo_level_t fifo_space;

	// one pass per line, eight columns
	logic [15:0] stim_mem [0:num_passes*stim_cols-1];
	integer      seed;

	// right bandpass reference state
	audio_pkg::coeff_t  bp_x1;
	audio_pkg::coeff_t  bp_x2;
	audio_pkg::coeff_t  bp_y1;
	audio_pkg::coeff_t  bp_y2;
	audio_pkg::sample_t bp_out;

	// decimated left path change history
	audio_pkg::sample_t last_left_wr;
	logic               change_win [$];

	audio_filter_top u_audio_filter_top (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.filter_right_en(filter_right_en),
		.filter_left_en (filter_left_en),
		.bus_ack        (bus_ack),
		.bus_read_data  (bus_read_data),
		.bus_addr       (bus_addr),
		.bus_byte_enable(bus_byte_enable),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_write_data (bus_write_data),
		.fifo_space     (fifo_space)
	);

	always #10 CLOCK_50 = ~CLOCK_50;

	////////////////////////////////////////
	// failure reporting and compares
	////////////////////////////////////////

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_sample(input string what, input audio_pkg::sample_t got,
			input audio_pkg::sample_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
			abort_run();
		end
	endtask

	task automatic check_space(input string what, input audio_pkg::fifo_level_t got,
			input audio_pkg::fifo_level_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
			abort_run();
		end
	endtask

	task automatic check_addr(input string what, input audio_pkg::bus_addr_t got,
			input audio_pkg::bus_addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// reference biquad
	////////////////////////////////////////

	// 18x18 product cut to 2.16, sign plus bits 32..16
	function automatic audio_pkg::coeff_t frac_mul(input audio_pkg::coeff_t c,
			input audio_pkg::coeff_t v);
		logic signed [35:0] p;
		p = c * v;
		return {p[35], p[32:16]};
	endfunction

	// output register lags the computed result by one input
	task automatic model_bandpass(input audio_pkg::sample_t x);
		audio_pkg::coeff_t xe;
		audio_pkg::coeff_t sum;
		xe  = {{2{x[15]}}, x};
		sum = frac_mul(audio_pkg::bp300_b1, xe) + frac_mul(audio_pkg::bp300_b2, bp_x1)
			+ frac_mul(audio_pkg::bp300_b3, bp_x2) + frac_mul(audio_pkg::bp300_a2, bp_y1)
			+ frac_mul(audio_pkg::bp300_a3, bp_y2);
		bp_out = bp_y1[15:0];
		bp_x2  = bp_x1;
		bp_x1  = xe;
		bp_y2  = bp_y1;
		bp_y1  = sum;
	endtask

	// slow bandpass output moves at most once per six written passes
	task automatic check_decim_rate(input audio_pkg::sample_t got, input logic restart);
		int changes;
		if (restart) begin
			change_win.delete();
		end
		change_win.push_back(!restart && (got != last_left_wr));
		if (change_win.size() > audio_pkg::decim_ratio) begin
			change_win.delete(0);
		end
		changes = 0;
		foreach (change_win[i]) begin
			changes += change_win[i];
		end
		if (changes > 1) begin
			$display("MISMATCH at %0t ns: decimated left output changed %0d times in %0d passes",
				$time, changes, change_win.size());
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// audio core bus model
	////////////////////////////////////////

	task automatic serve_request(input logic is_write, input audio_pkg::bus_addr_t addr,
			input audio_pkg::bus_data_t rdata, output audio_pkg::bus_data_t wdata);
		int waited;
		int delay;
		waited = 0;
		while (bus_read !== 1'b1 && bus_write !== 1'b1) begin
			if (waited == req_timeout) begin
				report_error($sformatf("no bus request within %0d cycles", req_timeout));
			end
			@(negedge CLOCK_50);
			waited++;
		end
		if (is_write && bus_write !== 1'b1) begin
			report_error("expected a bus write but the master issued a read");
		end
		if (!is_write && bus_read !== 1'b1) begin
			report_error("expected a bus read but the master issued a write");
		end
		if (bus_byte_enable !== audio_pkg::byte_en_all) begin
			report_error("bus request without all byte enables set");
		end
		check_addr("bus address", bus_addr, addr);
		// ack after 1 to 4 cycles, one cycle wide
		delay = 1 + ($unsigned($random(seed)) % 4);
		repeat (delay - 1) @(negedge CLOCK_50);
		bus_read_data = rdata;
		bus_ack       = 1'b1;
		wdata         = bus_write_data;
		@(negedge CLOCK_50);
		bus_ack = 1'b0;
	endtask

	// read and write never together
	always @(negedge CLOCK_50) begin
		if (reset === 1'b0 && bus_read === 1'b1 && bus_write === 1'b1) begin
			report_error("bus read and bus write are high at the same time");
		end
	end

	////////////////////////////////////////
	// pass sequencer
	////////////////////////////////////////

	initial begin
		int                     base;
		logic                   r_en;
		logic                   l_en;
		logic                   prev_l_en;
		audio_pkg::fifo_level_t ws;
		audio_pkg::fifo_level_t rl;
		audio_pkg::sample_t     in_l;
		audio_pkg::sample_t     in_r;
		audio_pkg::sample_t     exp_l;
		audio_pkg::sample_t     exp_r;
		audio_pkg::bus_data_t   status;
		audio_pkg::bus_data_t   wdata;

		CLOCK_50        = 1'b0;
		reset           = 1'b1;
		filter_right_en = 1'b0;
		filter_left_en  = 1'b0;
		bus_ack         = 1'b0;
		bus_read_data   = '0;
		seed            = 32'h79316b49;
		bp_x1           = '0;
		bp_x2           = '0;
		bp_y1           = '0;
		bp_y2           = '0;
		bp_out          = '0;
		last_left_wr    = '0;
		prev_l_en       = 1'b0;

		$readmemh("verif/audio_stimulus.txt", stim_mem);
		if ($isunknown(stim_mem[num_passes*stim_cols-1])) begin
			report_error("stimulus file is missing or has too few lines");
		end

		// bus stays quiet through reset
		repeat (5) begin
			@(negedge CLOCK_50);
			if (bus_read !== 1'b0 || bus_write !== 1'b0) begin
				report_error("bus request raised while reset is asserted");
			end
		end
		check_space("fifo_space after reset", fifo_space, '0);
		reset = 1'b0;

		for (int p = 0; p < num_passes; p++) begin
			base  = p * stim_cols;
			r_en  = stim_mem[base][0];
			l_en  = stim_mem[base+1][0];
			ws    = stim_mem[base+2][7:0];
			rl    = stim_mem[base+3][7:0];
			in_l  = stim_mem[base+4];
			in_r  = stim_mem[base+5];
			exp_l = stim_mem[base+6];
			exp_r = stim_mem[base+7];
			filter_right_en = r_en;
			filter_left_en  = l_en;
			// write space on top, read level at the bottom
			status = {ws, 16'h0000, rl};

			serve_request(1'b0, audio_pkg::audio_fifo_addr, status, wdata);
			check_space("write space", fifo_space, ws);
			if (ws > audio_pkg::write_space_min) begin
				serve_request(1'b1, audio_pkg::audio_left_addr, '0, wdata);
				if (l_en) begin
					check_decim_rate(wdata[15:0], !prev_l_en);
				end else begin
					check_sample("left loopback write", wdata[15:0], exp_l);
				end
				last_left_wr = wdata[15:0];
				prev_l_en    = l_en;

				serve_request(1'b1, audio_pkg::audio_right_addr, '0, wdata);
				if (r_en) begin
					check_sample("right bandpass write", wdata[15:0], bp_out);
				end else begin
					check_sample("right loopback write", wdata[15:0], exp_r);
				end

				serve_request(1'b0, audio_pkg::audio_fifo_addr, status, wdata);
				check_space("read level", fifo_space, rl);
				// empty read FIFO, master goes straight back to polling
				if (rl != '0) begin
					serve_request(1'b0, audio_pkg::audio_left_addr, {16'h0000, in_l}, wdata);
					serve_request(1'b0, audio_pkg::audio_right_addr, {16'h0000, in_r}, wdata);
					if (u_audio_filter_top.sample_valid !== 1'b1) begin
						report_error("no sample strobe one cycle after the right read");
					end
					model_bandpass(in_r);
				end
			end
		end

		$display("Test OK");
		$finish;
	end

endmodule

// ==== verif/audio_stimulus.txt ====
// right_en left_en write_space read_level left_in right_in exp_left exp_right
// exp columns hold the loopback value, the last samples read before the pass
0000 0000 0010 0004 0100 0200 0000 0000
0000 0000 0010 0004 0300 0400 0100 0200
0000 0000 0002 0004 0000 0000 0300 0400
0000 0000 0020 0000 0000 0000 0300 0400
0000 0000 0020 0003 0500 0600 0300 0400
0001 0000 0010 0004 4000 4000 0500 0600
0001 0000 0010 0004 c000 c000 4000 4000
0001 0000 0010 0004 7000 7000 c000 c000
0001 0000 0010 0004 9000 9000 7000 7000
0001 0000 0003 0004 2000 2000 9000 9000
0001 0000 0010 0000 0000 0000 2000 2000
0001 0000 0010 0004 6000 6000 2000 2000
0000 0001 0010 0004 7fff 1000 6000 6000
0000 0001 0010 0004 7fff 2000 7fff 1000
0001 0001 0010 0004 7fff 3000 7fff 2000
0001 0001 0010 0004 7fff 4000 7fff 3000
0001 0001 0010 0004 7fff 5000 7fff 4000
0001 0001 0002 0004 0000 0000 7fff 5000
0001 0001 0010 0004 7fff 6000 7fff 5000
0000 0000 0010 0004 0000 0000 7fff 6000

// ==== src.f ====
design/audio_pkg.sv
design/iir2_biquad.sv
design/audio_filter_bank.sv
design/audio_bus_master.sv
design/audio_filter_top.sv
verif/tb_audio_filter.sv

// ==== Bender.yml ====
package:
  name: audio_filter

sources:
  - design/audio_pkg.sv
  - design/iir2_biquad.sv
  - design/audio_filter_bank.sv
  - design/audio_bus_master.sv
  - design/audio_filter_top.sv
  - target: test
    files:
      - verif/tb_audio_filter.sv
